/* common/dsp_pkg.sv */
// Shared widths, operand types, opmode encoding and arbiter codes that every RTL file imports
package dsp_pkg;

    // ------------------------------
    // Data widths
    // ------------------------------
    localparam int data_width  = 48;                  // Operand and result width
    localparam int part_width  = 18;                  // Width of the D, A and B parts
    localparam int num_clients = 2;                   // Peer clients sharing the adder
    localparam int grant_width = $clog2(num_clients); // Client index width

    typedef logic signed [data_width-1:0] dsp_data_t; // Signed operand or result word

    // ------------------------------
    // Operation mode byte
    // ------------------------------
    typedef struct packed {
        logic       post_sub; // Subtract in the post-adder
        logic       pre_sub;  // Pre-adder direction kept for the format
        logic       carry_in; // Carry into the post-adder
        logic       pre_add;  // Pre-adder enable kept for the format
        logic [1:0] z_sel;    // 0 for zero and 3 for C
        logic [1:0] x_sel;    // 0 for zero and 3 for D:A:B
    } dsp_opmode_s;

    // Same byte seen raw for muxing or by field for decoding
    typedef union packed {
        logic [7:0]  raw;   // Whole byte
        dsp_opmode_s f;     // Named fields
    } dsp_opmode_u;

    localparam dsp_opmode_u op_add = 8'b0000_1111; // P = C + D:A:B with carry 0
    localparam dsp_opmode_u op_sub = 8'b1000_1111; // P = C - D:A:B with carry 0

    // ------------------------------
    // Arbiter FSM encoding
    // ------------------------------
    localparam int arb_state_width = 3;                       // State register width
    localparam logic [arb_state_width-1:0] st_idle    = 3'd0; // Waiting for any req
    localparam logic [arb_state_width-1:0] st_issue   = 3'd1; // Operands on the adder
    localparam logic [arb_state_width-1:0] st_wait    = 3'd2; // P valid and being latched
    localparam logic [arb_state_width-1:0] st_ack     = 3'd3; // Ack high to the winner
    localparam logic [arb_state_width-1:0] st_release = 3'd4; // Ack low before the next grant

endpackage

/* common/add_if.sv */
// One client's request path to the shared adder, used between each client and the arbiter
interface add_if import dsp_pkg::*; ();

    logic        req;    // Four-phase request from the client
    logic        ack;    // Four-phase acknowledge from the arbiter
    dsp_opmode_u opmode; // Requested operation
    dsp_data_t   dab;    // Concatenated D:A:B operand
    dsp_data_t   c;      // C operand
    dsp_data_t   p;      // Result, valid while ack is high

    // Client side owns the request and operands
    modport client (
        output req,
        output opmode,
        output dab,
        output c,
        input  ack,
        input  p
    );

    // Arbiter side answers with ack and result
    modport arbiter (
        input  req,
        input  opmode,
        input  dab,
        input  c,
        output ack,
        output p
    );

endinterface

/* src/dsp_adder.sv */
// Behavioral 48-bit add/subtract slice with registered output, driven by the shared arbiter
module dsp_adder import dsp_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  dsp_opmode_u opmode,
    input  dsp_data_t   dab,
    input  dsp_data_t   c,
    output dsp_data_t   p
);

    logic signed [part_width-1:0] d_part; // Upper part with only its low bits in X
    logic signed [part_width-1:0] a_part; // Middle part
    logic signed [part_width-1:0] b_part; // Low part
    dsp_data_t                    x_mux;  // X multiplexer output
    dsp_data_t                    z_mux;  // Z multiplexer output
    dsp_data_t                    cin_ext; // Carry widened to data width
    dsp_data_t                    post_sum; // Post-adder result before P register

    // ------------------------------
    // Operand split
    // ------------------------------
    // Zero-padded like the slice ports so D takes the top bits
    assign {d_part, a_part, b_part} = {{(3*part_width-data_width){1'b0}}, dab};

    // ------------------------------
    // X and Z multiplexers
    // ------------------------------
    always_comb begin
        case (opmode.f.x_sel)
            2'd3:    x_mux = {d_part[data_width-2*part_width-1:0], a_part, b_part}; // D:A:B
            default: x_mux = '0;  // Multiplier path not modeled
        endcase
    end

    always_comb begin
        case (opmode.f.z_sel)
            2'd3:    z_mux = c;   // C port
            default: z_mux = '0;  // Cascade path not modeled
        endcase
    end

    // ------------------------------
    // Post-adder and P register
    // ------------------------------
    assign cin_ext = {{(data_width-1){1'b0}}, opmode.f.carry_in};

    always_comb begin
        if (opmode.f.post_sub) begin
            post_sum = z_mux - (x_mux + cin_ext); // Z - (X + CIN)
        end else begin
            post_sum = z_mux + x_mux + cin_ext;   // Z + X + CIN
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            p <= '0;          // Cleared like the slice P register
        end else begin
            p <= post_sum;    // One cycle from operands to result
        end
    end

endmodule

/* arbiter/adder_arbiter.sv */
// Round-robin arbiter giving two four-phase clients turns on the single registered adder
module adder_arbiter import dsp_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    add_if.arbiter      client0,
    add_if.arbiter      client1,
    output dsp_opmode_u opmode,
    output dsp_data_t   dab,
    output dsp_data_t   c,
    input  dsp_data_t   p
);

    logic [arb_state_width-1:0] state;       // FSM state
    logic [grant_width-1:0]     grant;       // Client currently served
    logic [grant_width-1:0]     last_served; // Previous winner, for round-robin
    logic                       granted_req; // req of the granted client

    // ------------------------------
    // Operand mux to the adder
    // ------------------------------
    always_comb begin
        if (grant == '0) begin
            opmode.raw  = client0.opmode.raw; // Whole byte, no decode here
            dab         = client0.dab;
            c           = client0.c;
            granted_req = client0.req;
        end else begin
            opmode.raw  = client1.opmode.raw;
            dab         = client1.dab;
            c           = client1.c;
            granted_req = client1.req;
        end
        if (state == st_idle) begin
            opmode.raw = '0; // Zero X and Z, adder idles at 0
        end
    end

    // ------------------------------
    // Grant FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            grant       <= '0;
            last_served <= grant_width'(1); // Client 0 wins the first tie
        end else begin
            case (state)
                st_idle: begin
                    if (client0.req && client1.req) begin
                        // Tie goes to whoever did not win last
                        grant <= (last_served == '0) ? grant_width'(1) : '0;
                        state <= st_issue;
                    end else if (client1.req) begin
                        grant <= grant_width'(1);
                        state <= st_issue;
                    end else if (client0.req) begin
                        grant <= '0;
                        state <= st_issue;
                    end
                end
                st_issue: state <= st_wait;   // Adder registers this cycle
                st_wait:  state <= st_ack;    // P captured for the winner
                st_ack: begin
                    if (!granted_req) begin   // Client took the result
                        last_served <= grant;
                        state       <= st_release;
                    end
                end
                st_release: state <= st_idle; // Ack low for one cycle at least
                default:    state <= st_idle;
            endcase
        end
    end

    // ------------------------------
    // Result return
    // ------------------------------
    always_ff @(posedge clk) begin
        if (state == st_wait) begin
            if (grant == '0) begin
                client0.p <= p;   // Held until the next grant to this client
            end else begin
                client1.p <= p;
            end
        end
    end

    // Ack only to the winner, decoded from registered state
    assign client0.ack = (state == st_ack) && (grant == '0);
    assign client1.ack = (state == st_ack) && (grant != '0);

endmodule

/* src/phase_accumulator.sv */
// Phase accumulator client that steps a 48-bit phase through the shared adder while enabled
module phase_accumulator import dsp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      enable,
    input  dsp_data_t step,
    output dsp_data_t phase,
    output logic      phase_valid,
    add_if.client     bus
);

    logic start_req; // Launch a new add this cycle
    logic done;      // Adder result is being acknowledged

    // New request only once the previous handshake is fully closed
    assign start_req = enable && !bus.req && !bus.ack;
    assign done      = bus.req && bus.ack;

    assign bus.opmode = op_add; // Phase plus step

    // ------------------------------
    // Operand capture
    // ------------------------------
    always_ff @(posedge clk) begin
        if (start_req) begin
            bus.c   <= phase; // Z input, current phase
            bus.dab <= step;  // X input, step held for the request
        end
    end

    // ------------------------------
    // Handshake and phase register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.req     <= 1'b0;
            phase       <= '0;
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= 1'b0;          // Default, single-cycle pulse
            if (start_req) begin
                bus.req <= 1'b1;          // Operands stable from here on
            end else if (done) begin
                phase       <= bus.p;     // Wraps modulo 2**48
                phase_valid <= 1'b1;
                bus.req     <= 1'b0;      // Arbiter drops ack next
            end
        end
    end

endmodule

/* src/offset_corrector.sv */
// Offset corrector client that subtracts a stored offset from samples on a four-phase port
module offset_corrector import dsp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      offset_load,
    input  dsp_data_t offset_value,
    input  logic      sample_req,
    input  dsp_data_t sample,
    output logic      sample_ack,
    output dsp_data_t corrected,
    add_if.client     bus
);

    dsp_data_t offset;    // Stored offset
    logic      start_req; // Forward a new sample to the adder
    logic      done;      // Difference is being acknowledged

    // Fresh sample only when both handshakes are back at rest
    assign start_req = sample_req && !sample_ack && !bus.req && !bus.ack;
    assign done      = bus.req && bus.ack;

    assign bus.opmode = op_sub; // Sample minus offset

    always_ff @(posedge clk) begin
        if (start_req) begin
            bus.c   <= sample; // Z input
            bus.dab <= offset; // X input, offset at request time
        end
    end

    // ------------------------------
    // Offset and sample handshake
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            offset     <= '0;
            corrected  <= '0;
            sample_ack <= 1'b0;
            bus.req    <= 1'b0;
        end else begin
            if (offset_load) begin
                offset <= offset_value;   // Takes effect on the next sample
            end
            if (start_req) begin
                bus.req <= 1'b1;
            end else if (done) begin
                corrected  <= bus.p;      // Held while sample_ack is high
                sample_ack <= 1'b1;
                bus.req    <= 1'b0;
            end else if (sample_ack && !sample_req) begin
                sample_ack <= 1'b0;       // Source released the sample
            end
        end
    end

endmodule

/* src/adder_top.sv */
// Top level of the shared adder subsystem, wiring both clients through the arbiter to the adder
module adder_top import dsp_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      phase_enable,
    input  dsp_data_t phase_step,
    output dsp_data_t phase,
    output logic      phase_valid,
    input  logic      offset_load,
    input  dsp_data_t offset_value,
    input  logic      sample_req,
    input  dsp_data_t sample,
    output logic      sample_ack,
    output dsp_data_t corrected
);

    add_if phase_bus ();   // Client 0 path
    add_if offset_bus ();  // Client 1 path

    dsp_opmode_u adder_opmode; // Granted opmode to the adder
    dsp_data_t   adder_dab;    // Granted D:A:B operand
    dsp_data_t   adder_c;      // Granted C operand
    dsp_data_t   adder_p;      // Registered adder result

    // ------------------------------
    // Clients
    // ------------------------------
    phase_accumulator u_phase_accumulator (
        .clk         (clk),
        .reset       (reset),
        .enable      (phase_enable),
        .step        (phase_step),
        .phase       (phase),
        .phase_valid (phase_valid),
        .bus         (phase_bus)
    );

    offset_corrector u_offset_corrector (
        .clk          (clk),
        .reset        (reset),
        .offset_load  (offset_load),
        .offset_value (offset_value),
        .sample_req   (sample_req),
        .sample       (sample),
        .sample_ack   (sample_ack),
        .corrected    (corrected),
        .bus          (offset_bus)
    );

    // ------------------------------
    // Shared adder
    // ------------------------------
    adder_arbiter u_adder_arbiter (
        .clk     (clk),
        .reset   (reset),
        .client0 (phase_bus),
        .client1 (offset_bus),
        .opmode  (adder_opmode),
        .dab     (adder_dab),
        .c       (adder_c),
        .p       (adder_p)
    );

    dsp_adder u_dsp_adder (
        .clk    (clk),
        .reset  (reset),
        .opmode (adder_opmode),
        .dab    (adder_dab),
        .c      (adder_c),
        .p      (adder_p)
    );

endmodule

/* verification/tb_adder_top.sv */
// Self-checking testbench driving the shared adder top level with a sample table and phase steps
module tb_adder_top import dsp_pkg::*; ();

    localparam int num_cases    = 12;                   // Rows in the sample table
    localparam int first_shared = 6;                    // Rows from here run with the phase client on
    localparam int phase_steps  = 8;                    // Phase pulses per phase test
    localparam int quiet_cycles = 12;                   // Idle cycles that mean the phase client drained
    localparam int cycle_limit  = 20 * num_cases + 200; // Run limit

    typedef struct packed {
        dsp_data_t  offset;   // Offset in effect for the sample
        dsp_data_t  sample;   // Sample sent over the four-phase port
        dsp_data_t  expected; // Sample minus offset modulo 2**48
        logic [3:0] hold;     // Extra cycles sample_req stays high after ack
    } sample_case_t;

    logic      clk;
    logic      reset;
    logic      phase_enable;
    dsp_data_t phase_step;
    dsp_data_t phase;
    logic      phase_valid;
    logic      offset_load;
    dsp_data_t offset_value;
    logic      sample_req;
    dsp_data_t sample;
    logic      sample_ack;
    dsp_data_t corrected;

    sample_case_t cases [num_cases]; // Stimulus and expected values
    integer       seed;              // $random state
    dsp_data_t    model_phase;       // Software phase model
    dsp_data_t    model_step;        // Step the model adds per pulse
    int           phase_pulses;      // phase_valid pulses seen so far
    int           pulses_before;
    int           error_count;
    int           errors_at_start;
    int           tests_run;
    int           tests_failed;
    int           cycle_count;
    int           row;

    adder_top dut (
        .clk          (clk),
        .reset        (reset),
        .phase_enable (phase_enable),
        .phase_step   (phase_step),
        .phase        (phase),
        .phase_valid  (phase_valid),
        .offset_load  (offset_load),
        .offset_value (offset_value),
        .sample_req   (sample_req),
        .sample       (sample),
        .sample_ack   (sample_ack),
        .corrected    (corrected)
    );

    always #5 clk = ~clk; // Period 10

    // ------------------------------
    // Timeout and phase model
    // ------------------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!reset && phase_valid) begin
            model_phase = model_phase + model_step; // Wraps like the 48-bit phase
            check_data("phase", phase, model_phase);
            phase_pulses++;
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_data(input string name, input dsp_data_t got, input dsp_data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_at_start);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic build_table();
        logic [63:0] rnd;
        logic [31:0] rnd_hold;
        int          i;
        cases[0] = '{48'h0000_0000_0000, 48'h0000_1234_5678, 48'h0000_1234_5678, 4'd0};
        cases[1] = '{48'h0000_0000_0100, 48'h0000_0000_0050, 48'hffff_ffff_ff50, 4'd3}; // Negative
        cases[2] = '{48'h0000_0000_0001, 48'h8000_0000_0000, 48'h7fff_ffff_ffff, 4'd1}; // Wrap down
        cases[3] = '{48'hffff_ffff_ffff, 48'h7fff_ffff_ffff, 48'h8000_0000_0000, 4'd2}; // Wrap up
        cases[4] = '{48'hffff_ffff_ffff, 48'h0000_0012_3456, 48'h0000_0012_3457, 4'd0}; // Kept offset
        for (i = 5; i < num_cases; i++) begin
            rnd = {$random(seed), $random(seed)};
            cases[i].offset = rnd[47:0];
            rnd = {$random(seed), $random(seed)};
            cases[i].sample = rnd[47:0];
            cases[i].expected = cases[i].sample - cases[i].offset; // Table rule
            rnd_hold = $random(seed);
            cases[i].hold = {2'b00, rnd_hold[1:0]};
        end
    endtask

    // One row with offset load, four-phase sample, back-pressure hold and release
    task automatic apply_case(input int idx);
        dsp_data_t held;
        @(posedge clk);
        if (idx == 0 || cases[idx].offset != cases[idx-1].offset) begin
            offset_load  <= 1'b1;              // Only rows that bring a new offset
            offset_value <= cases[idx].offset;
        end
        @(posedge clk);
        offset_load  <= 1'b0;
        offset_value <= ~cases[idx].offset;    // Port moves on while the register holds
        sample_req   <= 1'b1;
        sample       <= cases[idx].sample;
        do @(negedge clk); while (!sample_ack);
        check_data("corrected", corrected, cases[idx].expected);
        held = corrected;
        repeat (cases[idx].hold) begin
            @(negedge clk);
            check_bit("sample_ack", sample_ack, 1'b1); // Still held
            check_data("corrected", corrected, held);
        end
        @(posedge clk);
        sample_req <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("sample_ack", sample_ack, 1'b0); // Falls the cycle after release
    endtask

    task automatic wait_phase_idle();
        int quiet;
        quiet = 0;
        while (quiet < quiet_cycles) begin
            @(negedge clk);
            if (phase_valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic run_phase(input dsp_data_t step);
        int target;
        target = phase_pulses + phase_steps;
        @(posedge clk);
        phase_step   <= step;
        model_step   <= step;
        phase_enable <= 1'b1;
        while (phase_pulses < target) @(negedge clk);
        @(posedge clk);
        phase_enable <= 1'b0;
        wait_phase_idle(); // In-flight step still checked by the model
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        clk = 1'b0;
        reset = 1'b1;
        phase_enable = 1'b0;
        phase_step = '0;
        offset_load = 1'b0;
        offset_value = '0;
        sample_req = 1'b0;
        sample = '0;
        seed = 32'hfb49;
        model_phase = '0;
        model_step = '0;
        phase_pulses = 0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_count = 0;
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        start_test();
        @(negedge clk);
        check_data("phase", phase, '0);
        check_data("corrected", corrected, '0);
        check_bit("phase_valid", phase_valid, 1'b0);
        check_bit("sample_ack", sample_ack, 1'b0);
        end_test("reset values");

        start_test();
        run_phase(48'h0000_0123_4567);
        end_test("phase step");

        start_test();
        run_phase(48'h7fff_ffff_fff3); // Near 2**47 so the phase wraps every second step
        end_test("phase wrap");

        start_test();
        for (row = 0; row < first_shared; row++) begin
            apply_case(row);
        end
        end_test("sample table with back-pressure and offset reloads");

        start_test();
        pulses_before = phase_pulses;
        @(posedge clk);
        phase_step   <= 48'h0000_0000_1001;
        model_step   <= 48'h0000_0000_1001;
        phase_enable <= 1'b1;
        for (row = first_shared; row < num_cases; row++) begin
            apply_case(row);
        end
        @(posedge clk);
        phase_enable <= 1'b0;
        wait_phase_idle();
        if (phase_pulses - pulses_before < num_cases - first_shared) begin
            $display("Phase accumulator stepped only %0d times while %0d samples ran",
                     phase_pulses - pulses_before, num_cases - first_shared);
            error_count++;
        end
        end_test("samples shared with phase accumulator");

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
common/dsp_pkg.sv
common/add_if.sv
src/dsp_adder.sv
arbiter/adder_arbiter.sv
src/phase_accumulator.sv
src/offset_corrector.sv
src/adder_top.sv
verification/tb_adder_top.sv

/* run.sh */
#!/bin/sh
# Builds the shared adder testbench with Verilator, runs it and judges the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --top-module tb_adder_top -Mdir "$OBJ_DIR" -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/Vtb_adder_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL, see $LOG"
    exit 1
fi
